/* logic/id_pkg.sv */
// decode stage shared definitions
`default_nettype none

package id_pkg;

  localparam int XLEN_DEF    = 32;
  localparam int INST_WD     = 32;
  localparam int REG_ADDR_WD = 5;

  // addi x0, x0, 0
  localparam logic [INST_WD-1:0] NOP_INST = 32'h0000_0013;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} br_kind_e;

endpackage

`default_nettype wire

/* logic/fwd_if.sv */
// bypass source bundle
`timescale 1ns/1ns
`default_nettype none

interface fwd_if #(
  parameter int XLEN = id_pkg::XLEN_DEF
);

  logic [id_pkg::REG_ADDR_WD-1:0] es_rd;
  logic [XLEN-1:0]                es_result;
  logic                           es_load;     // execute holds a load
  logic [id_pkg::REG_ADDR_WD-1:0] ms_rd;
  logic [XLEN-1:0]                ms_result;

  modport src (
    output es_rd, es_result, es_load, ms_rd, ms_result
  );

  modport dst (
    input es_rd, es_result, es_load, ms_rd, ms_result
  );

endinterface

`default_nettype wire

/* logic/ds_pipe_reg.sv */
// decode stage register
`timescale 1ns/1ns
`default_nettype none

module ds_pipe_reg #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_fs_valid,
  input  logic [id_pkg::INST_WD-1:0] i_fs_inst,
  input  logic [XLEN-1:0]            i_fs_pc,
  input  logic                       i_es_allowin,
  input  logic                       i_load_stall,
  input  logic                       i_br_taken,
  output logic [id_pkg::INST_WD-1:0] o_inst,
  output logic [XLEN-1:0]            o_pc,
  output logic                       o_ds_allowin,
  output logic                       o_ds_to_es_valid,
  output logic                       o_resolve
);

  logic ds_valid;
  logic ds_ready_go;
  logic fs_fire;

  assign ds_ready_go      = ~i_load_stall;
  assign o_ds_allowin     = ~ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = ds_valid & ds_ready_go;
  assign o_resolve        = ds_valid & ds_ready_go; // branch may only redirect from here
  assign fs_fire          = i_fs_valid & o_ds_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  // wrong-path fetch becomes a nop but keeps its pc
  always_ff @(posedge i_clk) begin
    if (fs_fire) begin
      o_inst <= i_br_taken ? id_pkg::NOP_INST : i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
// integer instruction decoder
`timescale 1ns/1ns
`default_nettype none

module inst_decoder #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input  logic [id_pkg::INST_WD-1:0]     i_inst,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rs1,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rs2,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]                o_imm,
  output id_pkg::alu_op_e                o_alu_op,
  output id_pkg::src1_sel_e              o_src1_sel,
  output id_pkg::src2_sel_e              o_src2_sel,
  output logic                           o_gpr_wen,
  output logic                           o_mem_ren,
  output logic                           o_mem_wen,
  output logic [2:0]                     o_mem_op,
  output logic                           o_load_sel,
  output id_pkg::br_kind_e               o_br_kind,
  output logic [2:0]                     o_br_func,
  output logic                           o_invalid
);

  id_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic            op_f7_ok;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  function automatic id_pkg::alu_op_e alu_from_funct(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode    = id_pkg::opcode_e'(i_inst[6:0]);
  assign funct3    = i_inst[14:12];
  assign o_rd      = i_inst[11:7];
  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_mem_op  = funct3;
  assign o_br_func = funct3;

  // sign extension up to XLEN through the signed cast
  assign imm_i = XLEN'($signed(i_inst[31:20]));
  assign imm_s = XLEN'($signed({i_inst[31:25], i_inst[11:7]}));
  assign imm_b = XLEN'($signed({i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0}));
  assign imm_u = XLEN'($signed({i_inst[31:12], 12'b0}));
  assign imm_j = XLEN'($signed({i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0}));

  // only sub and sra carry a nonzero funct7
  assign op_f7_ok = (i_inst[31:25] == 7'b0000000) ||
                    (i_inst[31:25] == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    o_imm      = '0;
    o_alu_op   = id_pkg::ALU_ADD;
    o_src1_sel = id_pkg::SRC1_RS1;
    o_src2_sel = id_pkg::SRC2_RS2;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_load_sel = 1'b0;
    o_br_kind  = id_pkg::BR_NONE;
    o_invalid  = 1'b0;
    case (opcode)
      id_pkg::OPC_LUI: begin
        o_imm      = imm_u;
        o_src1_sel = id_pkg::SRC1_ZERO;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = id_pkg::SRC1_PC;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        o_imm      = imm_j;
        o_src1_sel = id_pkg::SRC1_PC; // link value pc + 4
        o_src2_sel = id_pkg::SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_br_kind  = id_pkg::BR_JAL;
      end
      id_pkg::OPC_JALR: begin
        o_imm      = imm_i;
        o_src1_sel = id_pkg::SRC1_PC;
        o_src2_sel = id_pkg::SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_br_kind  = id_pkg::BR_JALR;
      end
      id_pkg::OPC_BRANCH: begin
        o_imm     = imm_b;
        o_br_kind = id_pkg::BR_COND;
        o_invalid = (funct3[2:1] == 2'b01); // no branch at 010/011
      end
      id_pkg::OPC_LOAD: begin
        o_imm      = imm_i;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_gpr_wen  = 1'b1;
        o_mem_ren  = 1'b1;
        o_load_sel = 1'b1;
      end
      id_pkg::OPC_STORE: begin
        o_imm      = imm_s;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_mem_wen  = 1'b1;
      end
      id_pkg::OPC_OP_IMM: begin
        o_imm      = imm_i;
        o_src2_sel = id_pkg::SRC2_IMM;
        o_alu_op   = alu_from_funct(funct3, (funct3 == 3'b101) & i_inst[30]);
        o_gpr_wen  = 1'b1;
      end
      id_pkg::OPC_OP: begin
        o_alu_op  = alu_from_funct(funct3, i_inst[30]);
        o_gpr_wen = 1'b1;
        o_invalid = ~op_f7_ok;
      end
      default: o_invalid = 1'b1;
    endcase
    if (o_invalid) begin
      o_gpr_wen  = 1'b0;
      o_mem_ren  = 1'b0;
      o_mem_wen  = 1'b0;
      o_load_sel = 1'b0;
      o_br_kind  = id_pkg::BR_NONE;
    end
  end

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
// integer register file
`timescale 1ns/1ns
`default_nettype none

module gpr_file #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_raddr1,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_raddr2,
  input  logic                           i_wen,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]                i_wdata,
  output logic [XLEN-1:0]                o_rdata1,
  output logic [XLEN-1:0]                o_rdata2
);

  logic [XLEN-1:0] regs [2**id_pkg::REG_ADDR_WD];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 2**id_pkg::REG_ADDR_WD; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 is hardwired
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

/* logic/operand_bypass.sv */
// operand forwarding and load-use detect
`timescale 1ns/1ns
`default_nettype none

module operand_bypass #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs1,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs2,
  input  logic [XLEN-1:0]                i_rf_rdata1,
  input  logic [XLEN-1:0]                i_rf_rdata2,
  fwd_if.dst                             fwd,
  output logic [XLEN-1:0]                o_rs1_data,
  output logic [XLEN-1:0]                o_rs2_data,
  output logic                           o_load_stall
);

  // execute wins over memory and x0 is never forwarded
  function automatic logic [XLEN-1:0] pick(logic [id_pkg::REG_ADDR_WD-1:0] rs,
                                           logic [XLEN-1:0] rf_data);
    if (fwd.es_rd != '0 && rs == fwd.es_rd) begin
      return fwd.es_result;
    end else if (fwd.ms_rd != '0 && rs == fwd.ms_rd) begin
      return fwd.ms_result;
    end
    return rf_data;
  endfunction

  always_comb begin
    o_rs1_data = pick(i_rs1, i_rf_rdata1);
    o_rs2_data = pick(i_rs2, i_rf_rdata2);
  end

  // load data is not back until the memory stage
  assign o_load_stall = fwd.es_load && (fwd.es_rd != '0) &&
                        ((fwd.es_rd == i_rs1) || (fwd.es_rd == i_rs2));

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
// branch and jump resolution
`timescale 1ns/1ns
`default_nettype none

module branch_unit #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input  logic             i_resolve,
  input  id_pkg::br_kind_e i_br_kind,
  input  logic [2:0]       i_br_func,
  input  logic [XLEN-1:0]  i_rs1_data,
  input  logic [XLEN-1:0]  i_rs2_data,
  input  logic [XLEN-1:0]  i_pc,
  input  logic [XLEN-1:0]  i_imm,
  input  logic [XLEN-1:0]  i_fs_pc,
  output logic             o_br_taken,
  output logic [XLEN-1:0]  o_br_target
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond_met;
  logic            take;
  logic [XLEN-1:0] pc_imm;
  logic [XLEN-1:0] reg_imm;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      3'b000:  cond_met = eq;
      3'b001:  cond_met = ~eq;
      3'b100:  cond_met = lt;
      3'b101:  cond_met = ~lt;
      3'b110:  cond_met = ltu;
      3'b111:  cond_met = ~ltu;
      default: cond_met = 1'b0;
    endcase
  end

  always_comb begin
    case (i_br_kind)
      id_pkg::BR_COND: take = cond_met;
      id_pkg::BR_JAL,
      id_pkg::BR_JALR: take = 1'b1;
      default:         take = 1'b0;
    endcase
  end

  assign pc_imm  = i_pc + i_imm;
  assign reg_imm = i_rs1_data + i_imm;

  assign o_br_target = !take                         ? i_pc + XLEN'(4) :
                       (i_br_kind == id_pkg::BR_JALR) ? {reg_imm[XLEN-1:1], 1'b0} :
                                                        pc_imm;

  // fetch already on the target means nothing to redirect
  assign o_br_taken = i_resolve && take && (o_br_target != i_fs_pc);

endmodule

`default_nettype wire

/* logic/id_stage.sv */
// instruction decode stage
`timescale 1ns/1ns
`default_nettype none

module id_stage #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  // from fetch
  input  logic                           i_fs_valid,
  input  logic [id_pkg::INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]                i_fs_pc,
  output logic                           o_ds_allowin,
  // to execute
  input  logic                           i_es_allowin,
  output logic                           o_ds_to_es_valid,
  // write back
  input  logic                           i_ws_wen,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ws_waddr,
  input  logic [XLEN-1:0]                i_ws_wdata,
  // bypass sources
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]                i_es_result,
  input  logic                           i_es_load,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]                i_ms_result,
  // decoded instruction
  output logic [XLEN-1:0]                o_pc,
  output logic [XLEN-1:0]                o_rs1_data,
  output logic [XLEN-1:0]                o_rs2_data,
  output logic [XLEN-1:0]                o_imm,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rd,
  output id_pkg::alu_op_e                o_alu_op,
  output id_pkg::src1_sel_e              o_src1_sel,
  output id_pkg::src2_sel_e              o_src2_sel,
  output logic                           o_gpr_wen,
  output logic                           o_mem_ren,
  output logic                           o_mem_wen,
  output logic [2:0]                     o_mem_op,
  output logic                           o_load_sel,
  output logic                           o_invalid,
  // redirect to fetch
  output logic                           o_br_taken,
  output logic [XLEN-1:0]                o_br_target
);

  logic [id_pkg::INST_WD-1:0]     ds_inst;
  logic [id_pkg::REG_ADDR_WD-1:0] rs1;
  logic [id_pkg::REG_ADDR_WD-1:0] rs2;
  logic [XLEN-1:0]                rf_rdata1;
  logic [XLEN-1:0]                rf_rdata2;
  id_pkg::br_kind_e               br_kind;
  logic [2:0]                     br_func;
  logic                           load_stall;
  logic                           resolve;

  fwd_if #(.XLEN(XLEN)) u_fwd ();

  // top ports feed the src side of the bundle
  assign u_fwd.es_rd     = i_es_rd;
  assign u_fwd.es_result = i_es_result;
  assign u_fwd.es_load   = i_es_load;
  assign u_fwd.ms_rd     = i_ms_rd;
  assign u_fwd.ms_result = i_ms_result;

  ds_pipe_reg #(.XLEN(XLEN)) u_pipe_reg (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_stall     (load_stall),
    .i_br_taken       (o_br_taken),
    .o_inst           (ds_inst),
    .o_pc             (o_pc),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_resolve        (resolve)
  );

  inst_decoder #(.XLEN(XLEN)) u_decoder (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_rd),
    .o_imm      (o_imm),
    .o_alu_op   (o_alu_op),
    .o_src1_sel (o_src1_sel),
    .o_src2_sel (o_src2_sel),
    .o_gpr_wen  (o_gpr_wen),
    .o_mem_ren  (o_mem_ren),
    .o_mem_wen  (o_mem_wen),
    .o_mem_op   (o_mem_op),
    .o_load_sel (o_load_sel),
    .o_br_kind  (br_kind),
    .o_br_func  (br_func),
    .o_invalid  (o_invalid)
  );

  gpr_file #(.XLEN(XLEN)) u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  operand_bypass #(.XLEN(XLEN)) u_bypass (
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rf_rdata1  (rf_rdata1),
    .i_rf_rdata2  (rf_rdata2),
    .fwd          (u_fwd),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data),
    .o_load_stall (load_stall)
  );

  branch_unit #(.XLEN(XLEN)) u_bru (
    .i_resolve   (resolve),
    .i_br_kind   (br_kind),
    .i_br_func   (br_func),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_pc        (o_pc),
    .i_imm       (o_imm),
    .i_fs_pc     (i_fs_pc),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

/* tests/id_stage_assertions.sv */
// decode stage handshake assertions
`timescale 1ns/1ns
`default_nettype none

module id_stage_assertions #(
  parameter int XLEN = id_pkg::XLEN_DEF
) (
  input logic            i_clk,
  input logic            i_rst_n,
  input logic            i_es_allowin,
  input logic            i_ds_to_es_valid,
  input logic            i_br_taken,
  input logic [XLEN-1:0] i_pc
);

  // nothing leaves decode under reset
  reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_ds_to_es_valid)
    else $error("valid to execute raised during reset");

  redirect_needs_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken |-> i_ds_to_es_valid)
    else $error("redirect without a ready instruction in decode");

  // held instruction while execute is stalled
  hold_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_to_es_valid && !i_es_allowin) |=> $stable(i_pc))
    else $error("decode pc changed under back-pressure");

endmodule

bind id_stage id_stage_assertions #(.XLEN(XLEN)) u_assertions (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_es_allowin     (i_es_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_br_taken       (o_br_taken),
  .i_pc             (o_pc)
);

`default_nettype wire

/* tests/tb_id_stage.sv */
// decode stage testbench
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;

  localparam int XLEN   = 32;
  localparam int PERIOD = 100;

  typedef struct packed {
    logic        keep;       // no new transfer, check what is latched
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        nx_valid;   // fetch offered during the check cycle
    logic [31:0] nx_inst;
    logic [31:0] fs_pc;
    logic        es_allowin;
    logic [4:0]  es_rd;
    logic [31:0] es_result;
    logic        es_load;
    logic [4:0]  ms_rd;
    logic [31:0] ms_result;
    logic [31:0] x_rs1;
    logic [31:0] x_rs2;
    logic [31:0] x_imm;
    logic [15:0] x_ctrl;
    logic [2:0]  x_hs;       // valid, allowin, taken
    logic [31:0] x_target;
  } row_t;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_fs_valid;
  logic [31:0]       i_fs_inst;
  logic [XLEN-1:0]   i_fs_pc;
  logic              o_ds_allowin;
  logic              i_es_allowin;
  logic              o_ds_to_es_valid;
  logic              i_ws_wen;
  logic [4:0]        i_ws_waddr;
  logic [XLEN-1:0]   i_ws_wdata;
  logic [4:0]        i_es_rd;
  logic [XLEN-1:0]   i_es_result;
  logic              i_es_load;
  logic [4:0]        i_ms_rd;
  logic [XLEN-1:0]   i_ms_result;
  logic [XLEN-1:0]   o_pc;
  logic [XLEN-1:0]   o_rs1_data;
  logic [XLEN-1:0]   o_rs2_data;
  logic [XLEN-1:0]   o_imm;
  logic [4:0]        o_rd;
  id_pkg::alu_op_e   o_alu_op;
  id_pkg::src1_sel_e o_src1_sel;
  id_pkg::src2_sel_e o_src2_sel;
  logic              o_gpr_wen;
  logic              o_mem_ren;
  logic              o_mem_wen;
  logic [2:0]        o_mem_op;
  logic              o_load_sel;
  logic              o_invalid;
  logic              o_br_taken;
  logic [XLEN-1:0]   o_br_target;

  row_t        cur;
  row_t        rows[$];
  string       names[$];
  logic [31:0] gpr_model [32];
  logic        pend_en;
  logic [4:0]  pend_addr;
  logic [31:0] pend_data;
  logic [15:0] lfsr;
  int          n_mismatch;
  int          n_other;
  int          cycles;
  int          cycle_limit = 64;

  id_stage #(.XLEN(XLEN)) dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #(PERIOD/2) i_clk = ~i_clk;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int k = 0; k < 32; k++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] up);
    return {up, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // en is {gpr_wen, mem_ren, mem_wen} and load_sel follows mem_ren
  function automatic logic [15:0] ctrl_word(id_pkg::alu_op_e a, id_pkg::src1_sel_e s1,
                                            id_pkg::src2_sel_e s2, logic [2:0] en,
                                            logic [2:0] mop, logic inv);
    return {a, s1, s2, en, en[1], mop, inv};
  endfunction

  function automatic logic [31:0] model_reg(logic [4:0] a);
    return (a == 5'd0) ? 32'd0 : gpr_model[a];
  endfunction

  task automatic queue_write(logic [4:0] a, logic [31:0] d);
    pend_en   = 1'b1;
    pend_addr = a;
    pend_data = d;
    if (a != 5'd0) begin
      gpr_model[a] = d;
    end
  endtask

  task automatic begin_row(logic [31:0] inst, logic [31:0] pc);
    cur            = '0;
    cur.wb_en      = pend_en;
    cur.wb_addr    = pend_addr;
    cur.wb_data    = pend_data;
    pend_en        = 1'b0;
    cur.inst       = inst;
    cur.pc         = pc;
    cur.fs_pc      = pc + 32'd4;
    cur.es_allowin = 1'b1;
    cur.x_rs1      = model_reg(inst[19:15]);
    cur.x_rs2      = model_reg(inst[24:20]);
    cur.x_hs       = 3'b110;
    cur.x_target   = pc + 32'd4;
  endtask

  task automatic commit_row(string name);
    rows.push_back(cur);
    names.push_back(name);
  endtask

  task automatic drive_idle();
    i_fs_valid   = 1'b0;
    i_fs_inst    = '0;
    i_fs_pc      = '0;
    i_es_allowin = 1'b1;
    i_ws_wen     = 1'b0;
    i_ws_waddr   = '0;
    i_ws_wdata   = '0;
    i_es_rd      = '0;
    i_es_result  = '0;
    i_es_load    = 1'b0;
    i_ms_rd      = '0;
    i_ms_result  = '0;
  endtask

  task automatic drive_check(row_t r);
    i_fs_valid   = r.nx_valid;
    i_fs_inst    = r.nx_inst;
    i_fs_pc      = r.fs_pc;
    i_es_allowin = r.es_allowin;
    i_ws_wen     = 1'b0;
    i_es_rd      = r.es_rd;
    i_es_result  = r.es_result;
    i_es_load    = r.es_load;
    i_ms_rd      = r.ms_rd;
    i_ms_result  = r.ms_result;
  endtask

  task automatic expect_eq(string name, string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_row(string name, row_t r);
    logic [15:0] ctrl_act;
    logic [2:0]  hs_act;
    ctrl_act = {o_alu_op, o_src1_sel, o_src2_sel, o_gpr_wen, o_mem_ren, o_mem_wen,
                o_load_sel, o_mem_op, o_invalid};
    hs_act   = {o_ds_to_es_valid, o_ds_allowin, o_br_taken};
    expect_eq(name, "valid/allowin/taken", 32'(r.x_hs), 32'(hs_act));
    expect_eq(name, "pc", r.pc, o_pc);
    expect_eq(name, "rd", 32'(r.inst[11:7]), 32'(o_rd));
    expect_eq(name, "imm", r.x_imm, o_imm);
    expect_eq(name, "ctrl", 32'(r.x_ctrl), 32'(ctrl_act));
    expect_eq(name, "rs1_data", r.x_rs1, o_rs1_data);
    expect_eq(name, "rs2_data", r.x_rs2, o_rs2_data);
    expect_eq(name, "target", r.x_target, o_br_target);
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      n_other++;
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    row_t        r;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] e;
    logic [31:0] m;
    logic [31:0] tmp;
    i_rst_n = 1'b0;
    drive_idle();
    lfsr    = 16'd21580;
    pend_en = 1'b0;
    for (int k = 0; k < 32; k++) begin
      gpr_model[k] = '0;
    end

    rand_word(r1);
    rand_word(r2);
    rand_word(e);
    rand_word(m);
    rand_word(tmp);

    queue_write(5'd1, r1);
    begin_row(enc_i(7'b0010011, 5'd5, 3'b000, 5'd1, 12'hff9), 32'h100);
    cur.x_imm  = 32'hffff_fff9;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM,
                           3'b100, 3'b000, 1'b0);
    commit_row("addi");
    queue_write(5'd2, r2);
    begin_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd6), 32'h104);
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                           3'b100, 3'b000, 1'b0);
    commit_row("add");
    begin_row(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd7), 32'h108);
    cur.x_ctrl = ctrl_word(id_pkg::ALU_SUB, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                           3'b100, 3'b000, 1'b0);
    commit_row("sub");
    begin_row(enc_u(7'b0110111, 5'd8, 20'habcde), 32'h10c);
    cur.x_imm  = 32'habcd_e000;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_ZERO, id_pkg::SRC2_IMM,
                           3'b100, 3'b110, 1'b0);
    commit_row("lui");
    begin_row(enc_u(7'b0010111, 5'd9, 20'h00012), 32'h200);
    cur.x_imm  = 32'h0001_2000;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_IMM,
                           3'b100, 3'b010, 1'b0);
    commit_row("auipc");
    begin_row(enc_i(7'b0000011, 5'd10, 3'b010, 5'd1, 12'h010), 32'h204);
    cur.x_imm  = 32'h0000_0010;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM,
                           3'b110, 3'b010, 1'b0);
    commit_row("lw");
    begin_row(enc_s(3'b010, 5'd1, 5'd2, 12'hffc), 32'h208);
    cur.x_imm  = 32'hffff_fffc;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM,
                           3'b001, 3'b010, 1'b0);
    commit_row("sw");
    queue_write(5'd0, tmp);
    begin_row(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd3), 32'h20c);
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                           3'b100, 3'b000, 1'b0);
    commit_row("x0_write");

    // bypass priority
    begin_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd11), 32'h300);
    cur.x_ctrl    = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                              3'b100, 3'b000, 1'b0);
    cur.es_rd     = 5'd1;
    cur.es_result = e;
    cur.ms_rd     = 5'd1;
    cur.ms_result = m;
    cur.x_rs1     = e;
    commit_row("fwd_es_over_ms");
    cur.pc        = 32'h304;
    cur.fs_pc     = 32'h308;
    cur.x_target  = 32'h308;
    cur.es_rd     = 5'd12;
    cur.x_rs1     = m;
    commit_row("fwd_ms_only");
    begin_row(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd12), 32'h308);
    cur.x_ctrl    = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                              3'b100, 3'b000, 1'b0);
    cur.es_result = e;
    cur.ms_result = m;
    commit_row("fwd_x0_ignored");

    // load-use stall then release
    begin_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd13), 32'h30c);
    cur.x_ctrl    = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                              3'b100, 3'b000, 1'b0);
    cur.es_rd     = 5'd2;
    cur.es_result = e;
    cur.es_load   = 1'b1;
    cur.x_rs2     = e;
    cur.x_hs      = 3'b000;
    commit_row("load_use_stall");
    cur.keep      = 1'b1;
    cur.es_load   = 1'b0;
    cur.x_hs      = 3'b110;
    commit_row("load_use_release");

    // branches and jumps
    begin_row(enc_b(3'b000, 5'd1, 5'd1, 13'h0040), 32'h400);
    cur.x_imm    = 32'h0000_0040;
    cur.x_ctrl   = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                             3'b000, 3'b000, 1'b0);
    cur.nx_valid = 1'b1;
    cur.nx_inst  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd14);
    cur.x_hs     = 3'b111;
    cur.x_target = 32'h0000_0440;
    commit_row("beq_taken");
    begin_row(32'h0000_0013, 32'h404);
    cur.keep   = 1'b1;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_IMM,
                           3'b100, 3'b000, 1'b0);
    commit_row("squashed_nop");
    queue_write(5'd4, 32'd5);
    begin_row(enc_b(3'b001, 5'd4, 5'd4, 13'h0008), 32'h500);
    cur.x_imm  = 32'h0000_0008;
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                           3'b000, 3'b001, 1'b0);
    commit_row("bne_not_taken");
    queue_write(5'd3, 32'hffff_fff0);
    begin_row(enc_b(3'b100, 5'd3, 5'd4, 13'h1fe0), 32'h600);
    cur.x_imm    = 32'hffff_ffe0;
    cur.x_ctrl   = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                             3'b000, 3'b100, 1'b0);
    cur.x_hs     = 3'b111;
    cur.x_target = 32'h0000_05e0;
    commit_row("blt_taken");
    begin_row(enc_b(3'b111, 5'd3, 5'd4, 13'h0100), 32'h700);
    cur.x_imm    = 32'h0000_0100;
    cur.x_ctrl   = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                             3'b000, 3'b111, 1'b0);
    cur.x_hs     = 3'b111;
    cur.x_target = 32'h0000_0800;
    commit_row("bgeu_taken");
    begin_row(enc_b(3'b000, 5'd4, 5'd4, 13'h0010), 32'h800);
    cur.x_imm    = 32'h0000_0010;
    cur.x_ctrl   = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                             3'b000, 3'b000, 1'b0);
    cur.fs_pc    = 32'h0000_0810;   // fetch already on the target
    cur.x_target = 32'h0000_0810;
    commit_row("beq_target_in_fetch");
    begin_row(enc_j(5'd1, 21'h000800), 32'h900);
    cur.x_imm    = 32'h0000_0800;
    cur.x_ctrl   = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_FOUR,
                             3'b100, 3'b000, 1'b0);
    cur.x_hs     = 3'b111;
    cur.x_target = 32'h0000_1100;
    commit_row("jal");
    begin_row(enc_i(7'b1100111, 5'd5, 3'b000, 5'd4, 12'h022), 32'ha00);
    cur.x_imm    = 32'h0000_0022;
    cur.x_ctrl   = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_PC, id_pkg::SRC2_FOUR,
                             3'b100, 3'b000, 1'b0);
    cur.x_hs     = 3'b111;
    cur.x_target = 32'h0000_0026;   // 5 + 0x22 with bit 0 cleared
    commit_row("jalr");

    // back-pressure and an unknown opcode
    begin_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd15), 32'hb00);
    cur.x_ctrl     = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                               3'b100, 3'b000, 1'b0);
    cur.es_allowin = 1'b0;
    cur.nx_valid   = 1'b1;   // fetch keeps offering while execute stalls
    cur.nx_inst    = enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd16);
    cur.x_hs       = 3'b100;
    commit_row("es_backpressure");
    cur.keep = 1'b1;
    commit_row("es_backpressure_hold");
    begin_row(32'h0000_007f, 32'hc00);
    cur.x_ctrl = ctrl_word(id_pkg::ALU_ADD, id_pkg::SRC1_RS1, id_pkg::SRC2_RS2,
                           3'b000, 3'b000, 1'b1);
    commit_row("invalid_opcode");

    cycle_limit = rows.size() * 4 + 64;

    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (!r.keep) begin
        if (r.wb_en) begin
          @(negedge i_clk);
          drive_idle();
          i_ws_wen   = 1'b1;
          i_ws_waddr = r.wb_addr;
          i_ws_wdata = r.wb_data;
          @(posedge i_clk);
        end
        @(negedge i_clk);
        drive_idle();
        i_fs_valid = 1'b1;
        i_fs_inst  = r.inst;
        i_fs_pc    = r.pc;
        #1;
        while (!o_ds_allowin) begin
          @(negedge i_clk);
          #1;
        end
        @(posedge i_clk);
      end
      @(negedge i_clk);
      drive_check(r);
      #(PERIOD/4);
      check_row(names[i], r);
      @(posedge i_clk);
    end

    @(negedge i_clk);
    drive_idle();
    repeat (2) @(posedge i_clk);
    $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/id_pkg.sv
logic/fwd_if.sv
logic/ds_pipe_reg.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
tests/id_stage_assertions.sv
tests/tb_id_stage.sv

/* Makefile */
TOP := tb_id_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
